//--- tb.f
+incdir+verification
hw/mm_cfg_pkg.sv
hw/mm_bus_pkg.sv
hw/matrix_ram.sv
hw/mm_sequencer.sv
hw/mac_accumulator.sv
hw/matmul_top.sv
verification/tb_matmul.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_matmul
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

# Build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/mm_tb_tasks.svh
`ifndef MM_TB_TASKS_SVH
`define MM_TB_TASKS_SVH

//////////////////////////////
// Helpers
//////////////////////////////

// Fibonacci LFSR on taps 32 22 2 1 stepped once per bit
function automatic mm_cfg_pkg::operand_t rand_operand();
        mm_cfg_pkg::operand_t val;
        logic                 fb;
        val = '0;
        for (int n = 0; n < mm_cfg_pkg::OPERAND_W; n++) begin
                fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
                lfsr_q = {lfsr_q[30:0], fb};
                val    = {val[mm_cfg_pkg::OPERAND_W-2:0], fb};
        end
        return val;
endfunction

task automatic check_val(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
                errors++;
                $display("MISMATCH %s expected 0x%08h actual 0x%08h", name, expected, actual);
        end
endtask

task automatic next_cycle();
        @(posedge clk);
        #1;  // Drive and sample clear of the edge
endtask

task automatic fill_random(input bit sel_b);
        for (int r = 0; r < MAT_DIM; r++) begin
                for (int c = 0; c < MAT_DIM; c++) begin
                        if (sel_b) b_m[r][c] = rand_operand();
                        else a_m[r][c] = rand_operand();
                end
        end
endtask

task automatic load_matrix(input bit sel_b);
        for (int r = 0; r < MAT_DIM; r++) begin
                for (int c = 0; c < MAT_DIM; c++) begin
                        load_i.valid    = 1'b1;
                        load_i.sel_b    = sel_b;
                        load_i.addr.row = mm_cfg_pkg::idx_t'(r);
                        load_i.addr.col = mm_cfg_pkg::idx_t'(c);
                        load_i.data     = sel_b ? b_m[r][c] : a_m[r][c];
                        next_cycle();
                end
        end
        load_i = '0;
endtask

// Sum of products wrapped to 32 bits
task automatic compute_expected();
        int acc;
        for (int i = 0; i < MAT_DIM; i++) begin
                for (int j = 0; j < MAT_DIM; j++) begin
                        acc = 0;
                        for (int k = 0; k < MAT_DIM; k++) begin
                                acc += int'(a_m[i][k]) * int'(b_m[k][j]);
                        end
                        exp_m[i][j] = acc;
                end
        end
endtask

task automatic run_matrix(input string name);
        int cycles;
        start_i = 1'b1;
        next_cycle();
        start_i = 1'b0;
        check_val({name, " busy after start"}, 32'd1, 32'(busy_o));
        check_val({name, " done after start"}, 32'd0, 32'(done_o));
        cycles = 0;
        while (!done_o && cycles <= RUN_CYCLES) begin
                start_i = (cycles == RUN_CYCLES / 2);  // Stray start mid-run, must be ignored
                next_cycle();
                cycles++;
        end
        start_i = 1'b0;
        if (!done_o) begin
                errors++;
                $display("%s: done_o never rose after start", name);
        end
        check_val({name, " run cycles"}, RUN_CYCLES, cycles);
        check_val({name, " busy at end"}, 32'd0, 32'(busy_o));
endtask

task automatic compare_results(input string name);
        for (int r = 0; r < MAT_DIM; r++) begin
                for (int c = 0; c < MAT_DIM; c++) begin
                        rd_addr_i.row = mm_cfg_pkg::idx_t'(r);
                        rd_addr_i.col = mm_cfg_pkg::idx_t'(c);
                        next_cycle();
                        check_val($sformatf("%s C[%0d][%0d]", name, r, c), exp_m[r][c], rd_data_o);
                end
        end
endtask

task automatic report_test(input string name, input int errs_before);
        $display("%s finished, %0d errors", name, errors - errs_before);
endtask

//////////////////////////////
// Directed tests
//////////////////////////////

task automatic test_reset_state();
        int errs;
        errs = errors;
        check_val("reset done_o", 32'd0, 32'(done_o));
        check_val("reset busy_o", 32'd0, 32'(busy_o));
        for (int r = 0; r < MAT_DIM; r++) begin
                for (int c = 0; c < MAT_DIM; c++) exp_m[r][c] = '0;
        end
        compare_results("test_reset_state");
        report_test("test_reset_state", errs);
endtask

// Every row holds its column number so C[i][j] = j * (0 + 1 + ... + 9)
task automatic test_ramp_pattern();
        int errs;
        errs = errors;
        for (int r = 0; r < MAT_DIM; r++) begin
                for (int c = 0; c < MAT_DIM; c++) begin
                        a_m[r][c]   = mm_cfg_pkg::operand_t'(c);
                        b_m[r][c]   = mm_cfg_pkg::operand_t'(c);
                        exp_m[r][c] = mm_cfg_pkg::result_t'(45 * c);
                end
        end
        load_matrix(1'b0);
        load_matrix(1'b1);
        run_matrix("test_ramp_pattern");
        compare_results("test_ramp_pattern");
        check_val("test_ramp_pattern done_o", 32'd1, 32'(done_o));  // Held through the reads
        report_test("test_ramp_pattern", errs);
endtask

task automatic test_identity();
        int errs;
        errs = errors;
        fill_random(1'b1);
        for (int r = 0; r < MAT_DIM; r++) begin
                for (int c = 0; c < MAT_DIM; c++) begin
                        a_m[r][c]   = (r == c) ? 16'sd1 : 16'sd0;
                        exp_m[r][c] = mm_cfg_pkg::result_t'(b_m[r][c]);  // C equals B
                end
        end
        load_matrix(1'b0);
        load_matrix(1'b1);
        run_matrix("test_identity");
        compare_results("test_identity");
        report_test("test_identity", errs);
endtask

task automatic test_random_signed();
        int errs;
        errs = errors;
        fill_random(1'b0);
        fill_random(1'b1);
        compute_expected();
        load_matrix(1'b0);
        load_matrix(1'b1);
        run_matrix("test_random_signed");
        compare_results("test_random_signed");
        report_test("test_random_signed", errs);
endtask

task automatic test_overflow_wrap();
        int                  errs;
        mm_cfg_pkg::result_t wrap_val;
        errs     = errors;
        wrap_val = mm_cfg_pkg::result_t'(64'd10 << 30);  // 10 * (-32768)^2 mod 2^32
        for (int r = 0; r < MAT_DIM; r++) begin
                for (int c = 0; c < MAT_DIM; c++) begin
                        a_m[r][c]   = 16'sh8000;
                        b_m[r][c]   = 16'sh8000;
                        exp_m[r][c] = wrap_val;
                end
        end
        load_matrix(1'b0);
        load_matrix(1'b1);
        run_matrix("test_overflow_wrap");
        compare_results("test_overflow_wrap");
        report_test("test_overflow_wrap", errs);
endtask

task automatic test_rerun();
        int errs;
        errs = errors;
        fill_random(1'b0);
        fill_random(1'b1);
        load_matrix(1'b0);
        load_matrix(1'b1);
        run_matrix("test_rerun first");
        fill_random(1'b1);  // New B only with A kept
        load_matrix(1'b1);
        compute_expected();
        check_val("test_rerun done_o before start", 32'd1, 32'(done_o));
        run_matrix("test_rerun second");
        compare_results("test_rerun");
        check_val("test_rerun done_o after run", 32'd1, 32'(done_o));
        report_test("test_rerun", errs);
endtask

`endif

//--- verification/tb_matmul.sv
`timescale 1ns/1ps

module tb_matmul;

        localparam int MAT_DIM        = mm_cfg_pkg::MAT_DIM;
        localparam int RUN_CYCLES     = MAT_DIM * MAT_DIM * MAT_DIM + 3;  // Start edge to done
        localparam int TIMEOUT_CYCLES = 20000;  // 6 runs plus loads and read sweeps, with margin

        logic                  clk;
        logic                  rst;
        mm_bus_pkg::load_req_t load_i;
        logic                  start_i;
        logic                  busy_o;
        logic                  done_o;
        mm_bus_pkg::mat_addr_t rd_addr_i;
        mm_cfg_pkg::result_t   rd_data_o;

        logic [31:0] lfsr_q;
        int          checks;
        int          errors;
        int          cycle_cnt = 0;

        // Reference copies of the operands and the expected product
        mm_cfg_pkg::operand_t a_m   [MAT_DIM][MAT_DIM];
        mm_cfg_pkg::operand_t b_m   [MAT_DIM][MAT_DIM];
        mm_cfg_pkg::result_t  exp_m [MAT_DIM][MAT_DIM];

        `include "mm_tb_tasks.svh"

        matmul_top UUT (
                .clk       (clk),
                .rst       (rst),
                .load_i    (load_i),
                .start_i   (start_i),
                .busy_o    (busy_o),
                .done_o    (done_o),
                .rd_addr_i (rd_addr_i),
                .rd_data_o (rd_data_o)
        );

        always #5 clk = ~clk;

        //////////////////////////////
        // Timeout
        //////////////////////////////
        always @(posedge clk) begin
                cycle_cnt <= cycle_cnt + 1;
                if (cycle_cnt >= TIMEOUT_CYCLES) begin
                        $display("Timeout: run went past %0d clock cycles", TIMEOUT_CYCLES);
                        $display("Checks failed");
                        $finish;
                end
        end

        initial begin
                clk       = 1'b0;
                rst       = 1'b1;
                load_i    = '0;
                start_i   = 1'b0;
                rd_addr_i = '0;
                lfsr_q    = 32'h326;
                checks    = 0;
                errors    = 0;
                repeat (5) @(posedge clk);
                #1;
                rst = 1'b0;

                test_reset_state();
                test_ramp_pattern();
                test_identity();
                test_random_signed();
                test_overflow_wrap();
                test_rerun();

                $display("Summary: %0d checks, %0d errors", checks, errors);
                if (errors == 0) begin
                        $display("All checks passed");
                end else begin
                        $display("Checks failed");
                end
                $finish;
        end

endmodule

//--- hw/matmul_top.sv
`timescale 1ns/1ps

module matmul_top (
        input  logic                  clk,
        input  logic                  rst,
        input  mm_bus_pkg::load_req_t load_i,
        input  logic                  start_i,
        output logic                  busy_o,
        output logic                  done_o,
        input  mm_bus_pkg::mat_addr_t rd_addr_i,
        output mm_cfg_pkg::result_t   rd_data_o
);

        logic                   a_wr_en;
        logic                   b_wr_en;
        mm_bus_pkg::mat_addr_t  a_addr;
        mm_bus_pkg::mat_addr_t  b_addr;
        mm_cfg_pkg::operand_t   a_data;
        mm_cfg_pkg::operand_t   b_data;
        mm_bus_pkg::mac_ctl_t   ctl;
        mm_bus_pkg::result_wr_t res_wr;
        logic                   last_wr;

        // Host load steering
        assign a_wr_en = load_i.valid && !load_i.sel_b;
        assign b_wr_en = load_i.valid && load_i.sel_b;

        //////////////////////////////
        // Operand memories
        //////////////////////////////
        matrix_ram #(
                .elem_t (mm_cfg_pkg::operand_t)
        ) u_mat_a (
                .clk       (clk),
                .rst       (rst),
                .wr_en_i   (a_wr_en),
                .wr_addr_i (load_i.addr),
                .wr_data_i (load_i.data),
                .rd_addr_i (a_addr),
                .rd_data_o (a_data)
        );

        matrix_ram #(
                .elem_t (mm_cfg_pkg::operand_t)
        ) u_mat_b (
                .clk       (clk),
                .rst       (rst),
                .wr_en_i   (b_wr_en),
                .wr_addr_i (load_i.addr),
                .wr_data_i (load_i.data),
                .rd_addr_i (b_addr),
                .rd_data_o (b_data)
        );

        //////////////////////////////
        // Walk and MAC
        //////////////////////////////
        mm_sequencer u_seq (
                .clk       (clk),
                .rst       (rst),
                .start_i   (start_i),
                .busy_o    (busy_o),
                .done_o    (done_o),
                .a_addr_o  (a_addr),
                .b_addr_o  (b_addr),
                .ctl_o     (ctl),
                .last_wr_i (last_wr)
        );

        mac_accumulator u_mac (
                .clk       (clk),
                .rst       (rst),
                .a_i       (a_data),
                .b_i       (b_data),
                .ctl_i     (ctl),
                .wr_o      (res_wr),
                .last_wr_o (last_wr)
        );

        // Result store, cleared on reset
        matrix_ram #(
                .elem_t       (mm_cfg_pkg::result_t),
                .CLEAR_ON_RST (1'b1)
        ) u_mat_c (
                .clk       (clk),
                .rst       (rst),
                .wr_en_i   (res_wr.valid),
                .wr_addr_i (res_wr.addr),
                .wr_data_i (res_wr.data),
                .rd_addr_i (rd_addr_i),
                .rd_data_o (rd_data_o)
        );

endmodule

//--- hw/mac_accumulator.sv
`timescale 1ns/1ps

module mac_accumulator (
        input  logic                   clk,
        input  logic                   rst,
        input  mm_cfg_pkg::operand_t   a_i,
        input  mm_cfg_pkg::operand_t   b_i,
        input  mm_bus_pkg::mac_ctl_t   ctl_i,
        output mm_bus_pkg::result_wr_t wr_o,
        output logic                   last_wr_o
);

        mm_cfg_pkg::result_t   prod;
        mm_cfg_pkg::result_t   sum;
        mm_cfg_pkg::result_t   acc_q;
        logic                  wr_vld_q;
        logic                  last_wr_q;
        mm_bus_pkg::mat_addr_t wr_addr_q;
        mm_cfg_pkg::result_t   wr_data_q;
        logic                  at_final;

        //////////////////////////////
        // Multiply-accumulate
        //////////////////////////////
        assign prod = mm_cfg_pkg::result_t'(a_i) * mm_cfg_pkg::result_t'(b_i);
        assign sum  = ctl_i.first ? prod : acc_q + prod;  // Wraps at 32 bits

        assign at_final = (ctl_i.dest.row == mm_cfg_pkg::IDX_LAST) &&
                          (ctl_i.dest.col == mm_cfg_pkg::IDX_LAST);

        always_ff @(posedge clk) begin
                if (ctl_i.valid) acc_q <= sum;
        end

        // Result write
        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        wr_vld_q  <= 1'b0;
                        last_wr_q <= 1'b0;
                end else begin
                        wr_vld_q  <= ctl_i.valid && ctl_i.last;
                        last_wr_q <= ctl_i.valid && ctl_i.last && at_final;
                end
        end

        always_ff @(posedge clk) begin
                if (ctl_i.valid && ctl_i.last) begin
                        wr_addr_q <= ctl_i.dest;
                        wr_data_q <= sum;
                end
        end

        assign wr_o      = '{valid: wr_vld_q, addr: wr_addr_q, data: wr_data_q};
        assign last_wr_o = last_wr_q;

        a_ctl_needs_valid: assert property (@(posedge clk) disable iff (rst)
                (ctl_i.first || ctl_i.last) |-> ctl_i.valid);

endmodule

//--- hw/mm_sequencer.sv
`timescale 1ns/1ps

module mm_sequencer (
        input  logic                  clk,
        input  logic                  rst,
        input  logic                  start_i,
        output logic                  busy_o,
        output logic                  done_o,
        output mm_bus_pkg::mat_addr_t a_addr_o,
        output mm_bus_pkg::mat_addr_t b_addr_o,
        output mm_bus_pkg::mac_ctl_t  ctl_o,
        input  logic                  last_wr_i
);

        logic                 busy_q;
        logic                 done_q;
        logic                 issue_q;  // Walk still issuing steps
        logic                 start_ok;
        mm_cfg_pkg::idx_t     row_q;
        mm_cfg_pkg::idx_t     col_q;
        mm_cfg_pkg::idx_t     k_q;
        mm_bus_pkg::mat_addr_t a_addr_q;
        mm_bus_pkg::mat_addr_t b_addr_q;
        mm_bus_pkg::mac_ctl_t  ctl_pre_q;  // Aligned with address
        mm_bus_pkg::mac_ctl_t  ctl_q;      // Aligned with read data

        assign start_ok = start_i && !busy_q;

        //////////////////////////////
        // Run control
        //////////////////////////////
        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        busy_q <= 1'b0;
                        done_q <= 1'b0;
                end else if (start_ok) begin
                        busy_q <= 1'b1;
                        done_q <= 1'b0;
                end else if (last_wr_i) begin
                        busy_q <= 1'b0;
                        done_q <= 1'b1;  // Final element stored
                end
        end

        //////////////////////////////
        // Row, column, inner walk
        //////////////////////////////
        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        issue_q <= 1'b0;
                        row_q   <= '0;
                        col_q   <= '0;
                        k_q     <= '0;
                end else if (start_ok) begin
                        issue_q <= 1'b1;
                        row_q   <= '0;
                        col_q   <= '0;
                        k_q     <= '0;
                end else if (issue_q) begin
                        if (k_q == mm_cfg_pkg::IDX_LAST) begin
                                k_q <= '0;
                                if (col_q == mm_cfg_pkg::IDX_LAST) begin
                                        col_q <= '0;
                                        if (row_q == mm_cfg_pkg::IDX_LAST) issue_q <= 1'b0;
                                        else row_q <= row_q + 1'b1;
                                end else begin
                                        col_q <= col_q + 1'b1;
                                end
                        end else begin
                                k_q <= k_q + 1'b1;
                        end
                end
        end

        always_ff @(posedge clk) begin
                a_addr_q <= '{row: row_q, col: k_q};
                b_addr_q <= '{row: k_q, col: col_q};
        end

        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        ctl_pre_q <= '0;
                        ctl_q     <= '0;
                end else begin
                        ctl_pre_q.valid <= issue_q;
                        ctl_pre_q.first <= issue_q && (k_q == '0);
                        ctl_pre_q.last  <= issue_q && (k_q == mm_cfg_pkg::IDX_LAST);
                        ctl_pre_q.dest  <= '{row: row_q, col: col_q};
                        ctl_q           <= ctl_pre_q;  // Match RAM latency
                end
        end

        assign busy_o   = busy_q;
        assign done_o   = done_q;
        assign a_addr_o = a_addr_q;
        assign b_addr_o = b_addr_q;
        assign ctl_o    = ctl_q;

        a_start_ignored: assert property (@(posedge clk) disable iff (rst)
                start_i && busy_q && !last_wr_i |=> busy_q);
        a_idx_range: assert property (@(posedge clk) disable iff (rst)
                issue_q |-> (row_q <= mm_cfg_pkg::IDX_LAST) &&
                            (col_q <= mm_cfg_pkg::IDX_LAST) &&
                            (k_q <= mm_cfg_pkg::IDX_LAST));

endmodule

//--- hw/matrix_ram.sv
`timescale 1ns/1ps

module matrix_ram #(
        parameter type elem_t       = mm_cfg_pkg::operand_t,
        parameter bit  CLEAR_ON_RST = 1'b0
) (
        input  logic                  clk,
        input  logic                  rst,
        input  logic                  wr_en_i,
        input  mm_bus_pkg::mat_addr_t wr_addr_i,
        input  elem_t                 wr_data_i,
        input  mm_bus_pkg::mat_addr_t rd_addr_i,
        output elem_t                 rd_data_o
);

        elem_t mem [mm_cfg_pkg::MAT_DIM][mm_cfg_pkg::MAT_DIM];

        if (CLEAR_ON_RST) begin : g_clr
                always_ff @(posedge clk or posedge rst) begin
                        if (rst) begin
                                for (int r = 0; r < mm_cfg_pkg::MAT_DIM; r++) begin
                                        for (int c = 0; c < mm_cfg_pkg::MAT_DIM; c++) begin
                                                mem[r][c] <= '0;
                                        end
                                end
                        end else if (wr_en_i) begin
                                mem[wr_addr_i.row][wr_addr_i.col] <= wr_data_i;
                        end
                end
        end else begin : g_noclr
                always_ff @(posedge clk) begin
                        if (wr_en_i) mem[wr_addr_i.row][wr_addr_i.col] <= wr_data_i;
                end
        end

        always_ff @(posedge clk) begin
                rd_data_o <= mem[rd_addr_i.row][rd_addr_i.col];  // One cycle read
        end

        a_wr_in_range: assert property (@(posedge clk) disable iff (rst)
                wr_en_i |-> (wr_addr_i.row <= mm_cfg_pkg::IDX_LAST) &&
                            (wr_addr_i.col <= mm_cfg_pkg::IDX_LAST));

endmodule

//--- hw/mm_bus_pkg.sv
package mm_bus_pkg;

        // Element address, row-major
        typedef struct packed {
                mm_cfg_pkg::idx_t row;
                mm_cfg_pkg::idx_t col;
        } mat_addr_t;

        // Host operand load
        typedef struct packed {
                logic                 valid;
                logic                 sel_b;  // 0 = A, 1 = B
                mat_addr_t            addr;
                mm_cfg_pkg::operand_t data;
        } load_req_t;

        // Travels alongside each operand pair
        typedef struct packed {
                logic      valid;
                logic      first;  // Starts a dot product
                logic      last;   // Ends a dot product
                mat_addr_t dest;
        } mac_ctl_t;

        typedef struct packed {
                logic                valid;
                mat_addr_t           addr;
                mm_cfg_pkg::result_t data;
        } result_wr_t;

endpackage

//--- hw/mm_cfg_pkg.sv
package mm_cfg_pkg;

        //////////////////////////////
        // Matrix dimensions
        //////////////////////////////
        localparam int MAT_DIM   = 10;  // Square side length
        localparam int IDX_W     = 4;   // Row, column or inner index
        localparam int OPERAND_W = 16;
        localparam int RESULT_W  = 32;

        //////////////////////////////
        // Element and index types
        //////////////////////////////
        typedef logic [IDX_W-1:0] idx_t;
        typedef logic signed [OPERAND_W-1:0] operand_t;
        typedef logic signed [RESULT_W-1:0] result_t;

        // Highest valid index on any axis
        localparam idx_t IDX_LAST = idx_t'(MAT_DIM - 1);

endpackage
